// File: build.f
+incdir+include
rtl/key_pkg.sv
rtl/cmd_pkg.sv
rtl/key_levels_if.sv
rtl/key_event_sync.sv
rtl/key_decoder.sv
rtl/button_debouncer.sv
rtl/input_manager.sv
rtl/game_input_top.sv
tb/game_input_sva.sv
tb/game_input_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := game_input_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/game_input_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module game_input_tb;

    localparam logic [31:0] SEED = 32'h0db4_2ff3;
    // Two DAS runs of up to 12 ticks plus the event tests and margin
    localparam int TIMEOUT_CYCLES = 100 * `TICK_CYCLES;

    logic       game_clk;
    logic       rst;
    logic       kb_req;
    logic       kb_ack;
    logic [7:0] kb_scan_code;
    logic       kb_make;
    logic       btn_left;
    logic       btn_right;
    logic       btn_down;
    logic       btn_rotate;
    logic       btn_drop;
    logic       tick;
    logic       cmd_left;
    logic       cmd_right;
    logic       cmd_down;
    logic       cmd_rotate;
    logic       cmd_drop;
    logic       cmd_hold;

    // Command outputs in game_cmd_t bit order with hold in bit 0
    logic [5:0] cmd_vec;
    string      cmd_name [6] = '{"cmd_hold", "cmd_drop", "cmd_rotate",
                                 "cmd_down", "cmd_right", "cmd_left"};

    // Monitor state
    int cmd_cnt [6];
    int base_cnt [6];
    int cycle;
    int tick_total;
    int last_tick_cycle;
    int tick_period;

    // Stimulus scratch
    int                 held;
    int                 t0;
    int                 hold_len;
    int                 k;
    int                 start;
    logic [7:0]         code;
    cmd_pkg::game_cmd_t sel;

    game_input_top dut (.*);

    assign cmd_vec = {cmd_left, cmd_right, cmd_down, cmd_rotate, cmd_drop, cmd_hold};

    initial begin
        game_clk = 1'b0;
        forever #10 game_clk = ~game_clk;
    end

    // ============================================================
    // Reference model and checks
    // ============================================================
    // One press gives one pulse and DAS keys add a repeat per completed span
    function automatic int model_pulses(input bit das_key, input int held_ticks);
        if (!das_key || held_ticks < `DAS_DELAY_TICKS) begin
            return 1;
        end
        return 2 + (held_ticks - `DAS_DELAY_TICKS) / `DAS_REPEAT_TICKS;
    endfunction

    function automatic bit is_game_code(input logic [7:0] c);
        return c == key_pkg::SC_LEFT || c == key_pkg::SC_RIGHT ||
               c == key_pkg::SC_DOWN || c == key_pkg::SC_ROTATE ||
               c == key_pkg::SC_DROP || c == key_pkg::SC_HOLD;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Pulses since the last snapshot are exp_sel on the selected commands and zero elsewhere
    task automatic check_counts(input cmd_pkg::game_cmd_t sel_cmd, input int exp_sel);
        logic [5:0] sel_bits;
        int         got;
        int         exp;
        sel_bits = sel_cmd;
        for (int i = 0; i < 6; i++) begin
            got = cmd_cnt[i] - base_cnt[i];
            exp = sel_bits[i] ? exp_sel : 0;
            check_int({cmd_name[i], " pulses"}, got, exp);
        end
    endtask

    task automatic take_snapshot();
        base_cnt = cmd_cnt;
    endtask

    // ============================================================
    // Stimulus helpers called on a falling edge
    // ============================================================
    task automatic send_event(input logic [7:0] sc, input logic mk);
        check_bit("kb_ack", kb_ack, 1'b0);
        kb_scan_code = sc;
        kb_make      = mk;
        kb_req       = 1'b1;
        repeat (`SYNC_STAGES + 1) @(negedge game_clk);
        check_bit("kb_ack", kb_ack, 1'b1);
        kb_req = 1'b0;
        // Receiver releases ack once it sees req low
        while (kb_ack) @(negedge game_clk);
    endtask

    task automatic wait_tick_total(input int target);
        while (tick_total < target) @(negedge game_clk);
    endtask

    // ============================================================
    // Monitor and timeout
    // ============================================================
    // Samples on the rising edge before the flops update
    always @(posedge game_clk) begin
        cycle = cycle + 1;
        if (!rst) begin
            for (int i = 0; i < 6; i++) begin
                if (cmd_vec[i]) begin
                    cmd_cnt[i]++;
                end
            end
            if (tick) begin
                if (last_tick_cycle >= 0) begin
                    tick_period = cycle - last_tick_cycle;
                end
                last_tick_cycle = cycle;
                tick_total++;
            end
        end
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_now($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        rst          = 1'b1;
        kb_req       = 1'b0;
        kb_scan_code = 8'h00;
        kb_make      = 1'b0;
        btn_left     = 1'b0;
        btn_right    = 1'b0;
        btn_down     = 1'b0;
        btn_rotate   = 1'b0;
        btn_drop     = 1'b0;
        cycle           = 0;
        tick_total      = 0;
        last_tick_cycle = -1;
        tick_period     = 0;
        for (int i = 0; i < 6; i++) begin
            cmd_cnt[i] = 0;
        end
        void'($urandom(SEED));

        repeat (16) @(negedge game_clk);
        rst = 1'b0;
        check_bit("kb_ack", kb_ack, 1'b0);
        check_bit("tick", tick, 1'b0);

        // Back to back make and break of drop
        take_snapshot();
        send_event(key_pkg::SC_DROP, 1'b1);
        send_event(key_pkg::SC_DROP, 1'b0);
        repeat (8) @(negedge game_clk);
        sel = '0;
        sel.drop = 1'b1;
        check_counts(sel, model_pulses(1'b0, 0));

        // One-shot keys in random order
        for (int n = 0; n < 8; n++) begin
            k        = $urandom % 3;
            hold_len = 4 + $urandom % 40;
            sel      = '0;
            case (k)
                0: begin
                    code       = key_pkg::SC_ROTATE;
                    sel.rotate = 1'b1;
                end
                1: begin
                    code     = key_pkg::SC_DROP;
                    sel.drop = 1'b1;
                end
                default: begin
                    code     = key_pkg::SC_HOLD;
                    sel.hold = 1'b1;
                end
            endcase
            take_snapshot();
            send_event(code, 1'b1);
            repeat (hold_len) @(negedge game_clk);
            check_counts(sel, model_pulses(1'b0, 0));
            send_event(code, 1'b0);
            repeat (8) @(negedge game_clk);
            check_counts(sel, model_pulses(1'b0, 0));
        end

        // Unknown codes over 200 cycles
        take_snapshot();
        start = cycle;
        while (cycle - start < 200) begin
            do begin
                code = 8'($urandom);
            end while (is_game_code(code));
            send_event(code, 1'b1);
            repeat (1 + $urandom % 8) @(negedge game_clk);
            send_event(code, 1'b0);
        end
        repeat (8) @(negedge game_clk);
        check_counts('0, 0);

        // DAS on left by keyboard with the press just after a tick
        held = 4 + $urandom % 7;
        take_snapshot();
        wait_tick_total(tick_total + 1);
        t0 = tick_total;
        send_event(key_pkg::SC_LEFT, 1'b1);
        wait_tick_total(t0 + held);
        send_event(key_pkg::SC_LEFT, 1'b0);
        repeat (10) @(negedge game_clk);
        sel = '0;
        sel.left = 1'b1;
        check_counts(sel, model_pulses(1'b1, held));

        // DAS on down by button where the debounce delay stays inside one tick
        held = 4 + $urandom % 7;
        take_snapshot();
        wait_tick_total(tick_total + 1);
        t0 = tick_total;
        btn_down = 1'b1;
        wait_tick_total(t0 + held);
        btn_down = 1'b0;
        repeat (`DEBOUNCE_CYCLES + 8) @(negedge game_clk);
        sel = '0;
        sel.down = 1'b1;
        check_counts(sel, model_pulses(1'b1, held));

        // Bouncing button that never settles and ends low
        take_snapshot();
        for (int n = 0; n < 6; n++) begin
            btn_left = ~btn_left;
            repeat (1 + $urandom % (`DEBOUNCE_CYCLES - 2)) @(negedge game_clk);
        end
        repeat (`DEBOUNCE_CYCLES + 5) @(negedge game_clk);
        check_counts('0, 0);

        // Stable rotate press
        take_snapshot();
        btn_rotate = 1'b1;
        repeat (`DEBOUNCE_CYCLES + 3) @(negedge game_clk);
        sel = '0;
        sel.rotate = 1'b1;
        check_counts(sel, 1);
        btn_rotate = 1'b0;
        repeat (`DEBOUNCE_CYCLES + 8) @(negedge game_clk);
        check_counts(sel, 1);

        // Distance between the last two ticks
        check_int("tick period", tick_period, `TICK_CYCLES);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/game_input_sva.sv
`timescale 1ns/1ps
`default_nettype none

module game_input_sva (
    input logic game_clk,
    input logic rst,
    input logic kb_req,
    input logic kb_ack,
    input logic tick,
    input logic cmd_left,
    input logic cmd_right,
    input logic cmd_down,
    input logic cmd_rotate,
    input logic cmd_drop,
    input logic cmd_hold
);

    // All one-cycle outputs, tick in the top bit
    logic [6:0] pulses;

    assign pulses = {tick, cmd_left, cmd_right, cmd_down, cmd_rotate, cmd_drop, cmd_hold};

    // ============================================================
    // Handshake
    // ============================================================
    // ack only answers a req that was already high
    ack_rise_needs_req: assert property (@(posedge game_clk) disable iff (rst)
        $rose(kb_ack) |-> $past(kb_req))
        else $error("kb_ack rose while kb_req was low");

    // ack is released only once the sender has dropped req
    ack_fall_after_req: assert property (@(posedge game_clk) disable iff (rst)
        $fell(kb_ack) |-> !$past(kb_req))
        else $error("kb_ack fell while kb_req was still high");

    // ============================================================
    // Pulses and reset state
    // ============================================================
    pulse_one_cycle: assert property (@(posedge game_clk) disable iff (rst)
        (pulses & $past(pulses)) == '0)
        else $error("command or tick held high for more than one cycle");

    reset_clears_outputs: assert property (@(posedge game_clk)
        rst |=> (!kb_ack && pulses == '0))
        else $error("outputs not low after reset");

endmodule

bind game_input_top game_input_sva u_sva (.*);

`default_nettype wire

// File: rtl/game_input_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_input_top (
    input  logic       game_clk,
    input  logic       rst,
    input  logic       kb_req,
    output logic       kb_ack,
    input  logic [7:0] kb_scan_code,
    input  logic       kb_make,
    input  logic       btn_left,
    input  logic       btn_right,
    input  logic       btn_down,
    input  logic       btn_rotate,
    input  logic       btn_drop,
    output logic       tick,
    output logic       cmd_left,
    output logic       cmd_right,
    output logic       cmd_down,
    output logic       cmd_rotate,
    output logic       cmd_drop,
    output logic       cmd_hold
);

    logic       ev_valid;
    logic [7:0] ev_code;
    logic       ev_make;

    // Debounced button levels
    logic [4:0] btn_raw;
    logic [4:0] btn_db;

    cmd_pkg::game_cmd_t cmds;

    key_levels_if kb_levels ();
    key_levels_if merged_levels ();

    // ============================================================
    // Keyboard path
    // ============================================================
    key_event_sync u_sync (
        .game_clk     (game_clk),
        .rst          (rst),
        .req          (kb_req),
        .ack          (kb_ack),
        .scan_code_in (kb_scan_code),
        .make_in      (kb_make),
        .event_valid  (ev_valid),
        .event_code   (ev_code),
        .event_make   (ev_make)
    );

    key_decoder u_decoder (
        .game_clk    (game_clk),
        .rst         (rst),
        .event_valid (ev_valid),
        .event_code  (ev_code),
        .event_make  (ev_make),
        .levels      (kb_levels)
    );

    // ============================================================
    // Buttons
    // ============================================================
    assign btn_raw = {btn_left, btn_right, btn_down, btn_rotate, btn_drop};

    for (genvar g = 0; g < 5; g++) begin : g_btn
        button_debouncer u_db (
            .game_clk (game_clk),
            .rst      (rst),
            .btn      (btn_raw[g]),
            .level    (btn_db[g])
        );
    end

    // Keyboard OR button, hold has no button
    assign merged_levels.left   = kb_levels.left   | btn_db[4];
    assign merged_levels.right  = kb_levels.right  | btn_db[3];
    assign merged_levels.down   = kb_levels.down   | btn_db[2];
    assign merged_levels.rotate = kb_levels.rotate | btn_db[1];
    assign merged_levels.drop   = kb_levels.drop   | btn_db[0];
    assign merged_levels.hold   = kb_levels.hold;

    input_manager u_mgr (
        .game_clk (game_clk),
        .rst      (rst),
        .levels   (merged_levels),
        .tick     (tick),
        .cmds     (cmds)
    );

    // Command struct out to plain ports
    assign cmd_left   = cmds.left;
    assign cmd_right  = cmds.right;
    assign cmd_down   = cmds.down;
    assign cmd_rotate = cmds.rotate;
    assign cmd_drop   = cmds.drop;
    assign cmd_hold   = cmds.hold;

endmodule

`default_nettype wire

// File: rtl/input_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module input_manager (
    input  logic               game_clk,
    input  logic               rst,
    key_levels_if.sink         levels,
    output logic               tick,
    output cmd_pkg::game_cmd_t cmds
);

    localparam int TICK_W  = $clog2(`TICK_CYCLES);
    localparam int DAS_MAX = (`DAS_DELAY_TICKS > `DAS_REPEAT_TICKS) ?
                             `DAS_DELAY_TICKS : `DAS_REPEAT_TICKS;
    localparam int DAS_W   = $clog2(DAS_MAX + 1);

    logic [TICK_W-1:0] tick_cnt;

    // Levels packed in game_cmd_t order, left in bit 5
    logic [5:0] lvl;
    logic [5:0] lvl_prev;
    logic [5:0] lvl_rise;

    // DAS slot i serves lvl bit 3+i (down, right, left)
    cmd_pkg::das_state_e das_state [3];
    logic [DAS_W-1:0]    das_cnt   [3];
    logic [2:0]          das_fire;

    assign lvl = {levels.left, levels.right, levels.down,
                  levels.rotate, levels.drop, levels.hold};

    assign lvl_rise = lvl & ~lvl_prev;

    // ============================================================
    // Game tick
    // ============================================================
    always_ff @(posedge game_clk) begin
        if (rst) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else if (tick_cnt == TICK_W'(`TICK_CYCLES - 1)) begin
            tick_cnt <= '0;
            tick     <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            tick     <= 1'b0;
        end
    end

    // ============================================================
    // Delayed auto-shift
    // ============================================================
    // Repeat fires on the tick that completes the current count
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            das_fire[i] = lvl[3+i] && !lvl_rise[3+i] && tick &&
                ((das_state[i] == cmd_pkg::DAS_DELAY &&
                  das_cnt[i] == DAS_W'(`DAS_DELAY_TICKS - 1)) ||
                 (das_state[i] == cmd_pkg::DAS_REPEAT &&
                  das_cnt[i] == DAS_W'(`DAS_REPEAT_TICKS - 1)));
        end
    end

    always_ff @(posedge game_clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                das_state[i] <= cmd_pkg::DAS_IDLE;
                das_cnt[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (!lvl[3+i]) begin
                    // Release
                    das_state[i] <= cmd_pkg::DAS_IDLE;
                    das_cnt[i]   <= '0;
                end else if (lvl_rise[3+i]) begin
                    // Fresh press, the one-shot pulse comes from lvl_rise
                    das_state[i] <= cmd_pkg::DAS_DELAY;
                    das_cnt[i]   <= '0;
                end else if (das_fire[i]) begin
                    das_state[i] <= cmd_pkg::DAS_REPEAT;
                    das_cnt[i]   <= '0;
                end else if (tick && das_state[i] != cmd_pkg::DAS_IDLE) begin
                    das_cnt[i] <= das_cnt[i] + 1'b1;
                end
            end
        end
    end

    // ============================================================
    // Edge detect and command register
    // ============================================================
    always_ff @(posedge game_clk) begin
        if (rst) begin
            lvl_prev <= '0;
            cmds     <= '0;
        end else begin
            lvl_prev <= lvl;
            cmds     <= cmd_pkg::game_cmd_t'(lvl_rise | {das_fire, 3'b000});
        end
    end

endmodule

`default_nettype wire

// File: rtl/button_debouncer.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module button_debouncer (
    input  logic game_clk,
    input  logic rst,
    input  logic btn,
    output logic level
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

    // Last sample of the raw button
    logic             sample;
    // Cycles since the raw input last changed
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge game_clk) begin
        if (rst) begin
            sample     <= 1'b0;
            stable_cnt <= '0;
            level      <= 1'b0;
        end else if (btn != sample) begin
            // Any bounce restarts the count
            sample     <= btn;
            stable_cnt <= CNT_W'(1);
        end else if (stable_cnt == CNT_W'(`DEBOUNCE_CYCLES)) begin
            // Stable long enough, counter holds here
            level <= sample;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
    input  logic         game_clk,
    input  logic         rst,
    input  logic         event_valid,
    input  logic [7:0]   event_code,
    input  logic         event_make,
    key_levels_if.source levels
);

    // ============================================================
    // Held key levels
    // ============================================================
    // Make sets the level, break clears it
    always_ff @(posedge game_clk) begin
        if (rst) begin
            levels.left   <= 1'b0;
            levels.right  <= 1'b0;
            levels.down   <= 1'b0;
            levels.rotate <= 1'b0;
            levels.drop   <= 1'b0;
            levels.hold   <= 1'b0;
        end else if (event_valid) begin
            case (key_pkg::scan_code_e'(event_code))
                key_pkg::SC_LEFT:   levels.left   <= event_make;
                key_pkg::SC_RIGHT:  levels.right  <= event_make;
                key_pkg::SC_DOWN:   levels.down   <= event_make;
                key_pkg::SC_ROTATE: levels.rotate <= event_make;
                key_pkg::SC_DROP:   levels.drop   <= event_make;
                key_pkg::SC_HOLD:   levels.hold   <= event_make;
                // Keys the game does not use
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/key_event_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module key_event_sync (
    input  logic       game_clk,
    input  logic       rst,
    input  logic       req,
    output logic       ack,
    input  logic [7:0] scan_code_in,
    input  logic       make_in,
    output logic       event_valid,
    output logic [7:0] event_code,
    output logic       event_make
);

    // Synchronizer chain on req, newest sample in bit 0
    logic [`SYNC_STAGES-1:0] req_sync;
    logic                    req_s;

    key_pkg::hs_state_e state;

    // ============================================================
    // req synchronizer
    // ============================================================
    always_ff @(posedge game_clk) begin
        if (rst) begin
            req_sync <= '0;
        end else begin
            req_sync <= {req_sync[`SYNC_STAGES-2:0], req};
        end
    end

    assign req_s = req_sync[`SYNC_STAGES-1];

    // ============================================================
    // Handshake FSM
    // ============================================================
    always_ff @(posedge game_clk) begin
        if (rst) begin
            state       <= key_pkg::HS_IDLE;
            event_valid <= 1'b0;
        end else begin
            // Pulse only on the entry edge
            event_valid <= 1'b0;
            case (state)
                key_pkg::HS_IDLE: begin
                    if (req_s) begin
                        state       <= key_pkg::HS_ACK;
                        event_valid <= 1'b1;
                    end
                end
                key_pkg::HS_ACK: begin
                    // Sender has dropped req, release ack
                    if (!req_s) begin
                        state <= key_pkg::HS_IDLE;
                    end
                end
                default: state <= key_pkg::HS_IDLE;
            endcase
        end
    end

    // Payload is stable while req is high, so capture on entry to HS_ACK
    always_ff @(posedge game_clk) begin
        if (state == key_pkg::HS_IDLE && req_s) begin
            event_code <= scan_code_in;
            event_make <= make_in;
        end
    end

    // ack rises on the same edge as the event pulse
    assign ack = (state == key_pkg::HS_ACK);

endmodule

`default_nettype wire

// File: rtl/key_levels_if.sv
`timescale 1ns/1ps
`default_nettype none

// Six held key levels, high while the key is down
interface key_levels_if;

    logic left;
    logic right;
    logic down;
    logic rotate;
    logic drop;
    logic hold;

    // Producer of the levels
    modport source (output left, right, down, rotate, drop, hold);

    // Consumer of the levels
    modport sink (input left, right, down, rotate, drop, hold);

endinterface

`default_nettype wire

// File: rtl/cmd_pkg.sv
`default_nettype none

// ============================================================
// Command side types
// ============================================================

package cmd_pkg;

    // One-cycle game commands, left in the top bit
    typedef struct packed {
        logic left;
        logic right;
        logic down;
        logic rotate;
        logic drop;
        logic hold;
    } game_cmd_t;

    // Per-key auto-shift state
    typedef enum logic [1:0] {
        DAS_IDLE   = 2'd0,
        DAS_DELAY  = 2'd1,
        DAS_REPEAT = 2'd2
    } das_state_e;

endpackage

`default_nettype wire

// File: rtl/key_pkg.sv
`default_nettype none

// ============================================================
// Keyboard side types
// ============================================================

package key_pkg;

    // PS/2 set 2 make codes used by the game
    typedef enum logic [7:0] {
        SC_HOLD   = 8'h12,
        SC_DROP   = 8'h29,
        SC_LEFT   = 8'h6B,
        SC_DOWN   = 8'h72,
        SC_RIGHT  = 8'h74,
        SC_ROTATE = 8'h75
    } scan_code_e;

    // Receiver side of the four-phase handshake
    // HS_ACK holds ack high until req drops
    typedef enum logic {
        HS_IDLE = 1'b0,
        HS_ACK  = 1'b1
    } hs_state_e;

endpackage

`default_nettype wire

// File: include/game_consts.svh
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// ============================================================
// Timing constants for the game input path
// ============================================================

// Cycles a button must stay stable before the level follows
`define DEBOUNCE_CYCLES 16

// game_clk cycles per game tick (about 416666 on hardware)
`define TICK_CYCLES 40

// DAS timing in game ticks
`define DAS_DELAY_TICKS 3
`define DAS_REPEAT_TICKS 1

// Depth of the req synchronizer
`define SYNC_STAGES 2

`endif
